// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f vlog.f \
    --top-module dcache_tb -Mdir obj_dir -o dcache_tb_sim

out="$(./obj_dir/dcache_tb_sim)"
echo "$out"

if ! grep -qx "TB PASSED" <<< "$out"; then
    echo "simulation did not report success"
    exit 1
fi

// File: source/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cache geometry, two ways of one word per line

// number of sets per way
`define DC_SETS 256

// set index, word address bits 9:2
`define DC_INDEX_W 8

// tag, word address bits 18:10
`define DC_TAG_W 9

// whole word address, bits 18:2
`define DC_WORD_ADDR_W 17

`endif

// File: source/dcache_ctrl.sv
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // core port
    input  logic                   core_sel_i,
    input  dcache_pkg::word_addr_t core_addr_i,
    input  dcache_pkg::word_t      core_wdata_i,
    input  dcache_pkg::byte_mask_t core_wmask_i,
    output dcache_pkg::word_t      core_rdata_o,
    output logic                   core_stall_o,
    // memory port
    output dcache_pkg::word_addr_t mem_addr_o,
    output logic                   mem_valid_o,
    output dcache_pkg::word_t      mem_wdata_o,
    output dcache_pkg::byte_mask_t mem_wstrb_o,
    input  dcache_pkg::word_t      mem_rdata_i,
    input  logic                   mem_ready_i,
    // way rams
    output logic                   ram_rd_en_o,
    output logic [1:0]             ram_wr_en_o,
    output dcache_pkg::set_idx_t   ram_wr_idx_o,
    output dcache_pkg::tag_t       ram_wr_tag_o,
    output dcache_pkg::word_t      ram_wr_data_o,
    output dcache_pkg::byte_mask_t ram_wr_mask_o,
    input  dcache_pkg::tag_t       ram0_tag_i,
    input  dcache_pkg::tag_t       ram1_tag_i,
    input  dcache_pkg::word_t      ram0_data_i,
    input  dcache_pkg::word_t      ram1_data_i,
    // line state
    input  logic [1:0]             st_valid_i,
    input  logic [1:0]             st_dirty_i,
    input  dcache_pkg::way_t       st_victim_i,
    output logic                   upd_en_o,
    output dcache_pkg::way_t       upd_way_o,
    output logic                   upd_dirty_o
);
    import dcache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // request fields
    tag_t     req_tag;
    set_idx_t req_idx;
    logic     is_write;
    logic     full_write;

    // lookup results
    logic  hit0;
    logic  hit1;
    logic  hit;
    way_t  hit_way;
    word_t hit_data;
    logic  victim_dirty;

    // latched across the miss sequence
    logic       hit_q;
    way_t       tgt_way_q;
    word_addr_t victim_addr_q;
    word_t      victim_data_q;
    word_t      fill_q;
    word_t      rdata_q;
    word_t      merged;

    assign req_tag    = core_addr_i[`DC_WORD_ADDR_W-1 -: `DC_TAG_W];
    assign req_idx    = core_addr_i[`DC_INDEX_W-1:0];
    assign is_write   = |core_wmask_i;
    assign full_write = &core_wmask_i;

    // tag compare is only meaningful in LOOKUP
    assign hit0     = st_valid_i[0] && (ram0_tag_i == req_tag);
    assign hit1     = st_valid_i[1] && (ram1_tag_i == req_tag);
    assign hit      = hit0 || hit1;
    assign hit_way  = way_t'(hit1);
    assign hit_data = hit1 ? ram1_data_i : ram0_data_i;

    assign victim_dirty = st_valid_i[st_victim_i] && st_dirty_i[st_victim_i];

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (core_sel_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = is_write ? UPDATE : DONE;
                end else if (victim_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    // full words allocate without a fetch
                    state_d = full_write ? UPDATE : REFILL;
                end
            end
            WRITEBACK: begin
                if (mem_ready_i) begin
                    state_d = full_write ? UPDATE : REFILL;
                end
            end
            REFILL: begin
                if (mem_ready_i) begin
                    state_d = UPDATE;
                end
            end
            UPDATE: begin
                state_d = DONE;
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= IDLE;
            hit_q     <= 1'b0;
            tgt_way_q <= way_t'(1'b0);
        end else begin
            state_q <= state_d;
            if (state_q == LOOKUP) begin
                hit_q     <= hit;
                tgt_way_q <= hit ? hit_way : st_victim_i;
            end
        end
    end

    // victim copy for the write-back plus the refill word and read result
    always_ff @(posedge clk_i) begin
        if (state_q == LOOKUP) begin
            victim_addr_q <= {(st_victim_i ? ram1_tag_i : ram0_tag_i), req_idx};
            victim_data_q <= st_victim_i ? ram1_data_i : ram0_data_i;
            if (hit) begin
                rdata_q <= hit_data;
            end
        end
        if (state_q == REFILL && mem_ready_i) begin
            fill_q  <= mem_rdata_i;
            rdata_q <= mem_rdata_i;
        end
    end

    // enabled core bytes over the fetched word
    always_comb begin
        merged = fill_q;
        for (int b = 0; b < 4; b++) begin
            if (core_wmask_i[b]) begin
                merged[b*8 +: 8] = core_wdata_i[b*8 +: 8];
            end
        end
    end

    // core side
    assign core_rdata_o = rdata_q;
    assign core_stall_o = core_sel_i && (state_q != DONE);

    // memory requests held steady by the state and the latched victim
    assign mem_valid_o = (state_q == WRITEBACK) || (state_q == REFILL);
    assign mem_addr_o  = (state_q == WRITEBACK) ? victim_addr_q : core_addr_i;
    assign mem_wdata_o = (state_q == WRITEBACK) ? victim_data_q : '0;
    assign mem_wstrb_o = (state_q == WRITEBACK) ? 4'hF : 4'h0;

    // read both ways as the request arrives
    assign ram_rd_en_o = (state_q == IDLE) && core_sel_i;

    // way write in UPDATE
    // a hit write uses the byte mask while a fill writes the whole word
    assign ram_wr_en_o   = (state_q == UPDATE) ? (2'b01 << tgt_way_q) : 2'b00;
    assign ram_wr_idx_o  = req_idx;
    assign ram_wr_tag_o  = req_tag;
    assign ram_wr_data_o = hit_q ? core_wdata_i : merged;
    assign ram_wr_mask_o = hit_q ? core_wmask_i : 4'hF;

    // read hits only refresh lru and keep the dirty bit
    assign upd_en_o    = (state_q == UPDATE) || (state_q == LOOKUP && hit && !is_write);
    assign upd_way_o   = (state_q == LOOKUP) ? hit_way : tgt_way_q;
    assign upd_dirty_o = (state_q == LOOKUP) ? st_dirty_i[hit_way] : is_write;

    // memory request held until the ready pulse
    a_mem_hold : assert property (
        @(posedge clk_i) disable iff (rst_i)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o)
    );

    // address, mask and data stay live for the whole miss sequence
    a_req_hold : assert property (
        @(posedge clk_i) disable iff (rst_i)
        core_sel_i && core_stall_o |=> core_sel_i && $stable(core_addr_i)
            && $stable(core_wmask_i) && $stable(core_wdata_i)
    );

endmodule

// File: source/dcache_line_state.sv
`include "dcache_cfg.svh"

module dcache_line_state (
    input  logic                 clk_i,
    input  logic                 rst_i,
    // lookup of the requested set
    input  dcache_pkg::set_idx_t idx_i,
    output logic [1:0]           valid_o,
    output logic [1:0]           dirty_o,
    output dcache_pkg::way_t     victim_o,
    // update from the controller
    input  logic                 upd_en_i,
    input  dcache_pkg::way_t     upd_way_i,
    input  logic                 upd_dirty_i
);
    import dcache_pkg::*;

    // one bit per way per set
    logic [1:0]          valid_q [`DC_SETS];
    logic [1:0]          dirty_q [`DC_SETS];
    // lru bit names the least recently used way
    logic [`DC_SETS-1:0] lru_q;

    assign valid_o = valid_q[idx_i];
    assign dirty_o = dirty_q[idx_i];

    // invalid way first, lowest one wins
    always_comb begin
        if (!valid_o[0]) begin
            victim_o = way_t'(1'b0);
        end else if (!valid_o[1]) begin
            victim_o = way_t'(1'b1);
        end else begin
            victim_o = way_t'(lru_q[idx_i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s] <= 2'b00;
                dirty_q[s] <= 2'b00;
            end
            lru_q <= '0;
        end else if (upd_en_i) begin
            valid_q[idx_i][upd_way_i] <= 1'b1;
            dirty_q[idx_i][upd_way_i] <= upd_dirty_i;
            // touched way becomes most recent
            lru_q[idx_i] <= ~upd_way_i;
        end
    end

    // a dirty line must also be valid
    a_dirty_valid : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (dirty_o & ~valid_o) == 2'b00
    );

endmodule

// File: source/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

    // data word and byte enables
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_mask_t;

    // word address is {tag, index}
    typedef logic [`DC_WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [`DC_TAG_W-1:0]       tag_t;
    typedef logic [`DC_INDEX_W-1:0]     set_idx_t;

    // way number, two ways
    typedef logic way_t;

    // miss handling states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        UPDATE,
        DONE
    } ctrl_state_e;

endpackage

// File: source/dcache_top.sv
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // core port
    input  logic                   core_sel_i,
    input  dcache_pkg::word_addr_t core_addr_i,
    input  dcache_pkg::word_t      core_wdata_i,
    input  dcache_pkg::byte_mask_t core_wmask_i,
    output dcache_pkg::word_t      core_rdata_o,
    output logic                   core_stall_o,
    // memory port
    output dcache_pkg::word_addr_t mem_addr_o,
    output logic                   mem_valid_o,
    output dcache_pkg::word_t      mem_wdata_o,
    output dcache_pkg::byte_mask_t mem_wstrb_o,
    input  dcache_pkg::word_t      mem_rdata_i,
    input  logic                   mem_ready_i
);
    import dcache_pkg::*;

    // controller to way rams
    logic       ram_rd_en;
    logic [1:0] ram_wr_en;
    set_idx_t   ram_wr_idx;
    tag_t       ram_wr_tag;
    word_t      ram_wr_data;
    byte_mask_t ram_wr_mask;
    tag_t       ram0_tag;
    tag_t       ram1_tag;
    word_t      ram0_data;
    word_t      ram1_data;

    // controller to line state
    logic [1:0] st_valid;
    logic [1:0] st_dirty;
    way_t       st_victim;
    logic       upd_en;
    way_t       upd_way;
    logic       upd_dirty;

    dcache_ctrl i_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .core_sel_i    (core_sel_i),
        .core_addr_i   (core_addr_i),
        .core_wdata_i  (core_wdata_i),
        .core_wmask_i  (core_wmask_i),
        .core_rdata_o  (core_rdata_o),
        .core_stall_o  (core_stall_o),
        .mem_addr_o    (mem_addr_o),
        .mem_valid_o   (mem_valid_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_wstrb_o   (mem_wstrb_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_ready_i   (mem_ready_i),
        .ram_rd_en_o   (ram_rd_en),
        .ram_wr_en_o   (ram_wr_en),
        .ram_wr_idx_o  (ram_wr_idx),
        .ram_wr_tag_o  (ram_wr_tag),
        .ram_wr_data_o (ram_wr_data),
        .ram_wr_mask_o (ram_wr_mask),
        .ram0_tag_i    (ram0_tag),
        .ram1_tag_i    (ram1_tag),
        .ram0_data_i   (ram0_data),
        .ram1_data_i   (ram1_data),
        .st_valid_i    (st_valid),
        .st_dirty_i    (st_dirty),
        .st_victim_i   (st_victim),
        .upd_en_o      (upd_en),
        .upd_way_o     (upd_way),
        .upd_dirty_o   (upd_dirty)
    );

    // way 0
    dcache_way_ram i_way0 (
        .clk_i     (clk_i),
        .wr_en_i   (ram_wr_en[0]),
        .wr_idx_i  (ram_wr_idx),
        .wr_tag_i  (ram_wr_tag),
        .wr_data_i (ram_wr_data),
        .wr_mask_i (ram_wr_mask),
        .rd_en_i   (ram_rd_en),
        .rd_idx_i  (core_addr_i[`DC_INDEX_W-1:0]),
        .rd_tag_o  (ram0_tag),
        .rd_data_o (ram0_data)
    );

    // way 1
    dcache_way_ram i_way1 (
        .clk_i     (clk_i),
        .wr_en_i   (ram_wr_en[1]),
        .wr_idx_i  (ram_wr_idx),
        .wr_tag_i  (ram_wr_tag),
        .wr_data_i (ram_wr_data),
        .wr_mask_i (ram_wr_mask),
        .rd_en_i   (ram_rd_en),
        .rd_idx_i  (core_addr_i[`DC_INDEX_W-1:0]),
        .rd_tag_o  (ram1_tag),
        .rd_data_o (ram1_data)
    );

    dcache_line_state i_line_state (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .idx_i       (core_addr_i[`DC_INDEX_W-1:0]),
        .valid_o     (st_valid),
        .dirty_o     (st_dirty),
        .victim_o    (st_victim),
        .upd_en_i    (upd_en),
        .upd_way_i   (upd_way),
        .upd_dirty_i (upd_dirty)
    );

endmodule

// File: source/dcache_way_ram.sv
`include "dcache_cfg.svh"

module dcache_way_ram (
    input  logic                   clk_i,
    // write port
    input  logic                   wr_en_i,
    input  dcache_pkg::set_idx_t   wr_idx_i,
    input  dcache_pkg::tag_t       wr_tag_i,
    input  dcache_pkg::word_t      wr_data_i,
    input  dcache_pkg::byte_mask_t wr_mask_i,
    // read port
    input  logic                   rd_en_i,
    input  dcache_pkg::set_idx_t   rd_idx_i,
    output dcache_pkg::tag_t       rd_tag_o,
    output dcache_pkg::word_t      rd_data_o
);
    import dcache_pkg::*;

    // behavioural model of the 1w/1r sram macro
    tag_t  tag_mem  [`DC_SETS];
    word_t data_mem [`DC_SETS];

    // tag always written, data per byte lane
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_mem[wr_idx_i] <= wr_tag_i;
            for (int b = 0; b < 4; b++) begin
                if (wr_mask_i[b]) begin
                    data_mem[wr_idx_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    // registered read, outputs hold between reads
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_tag_o  <= tag_mem[rd_idx_i];
            rd_data_o <= data_mem[rd_idx_i];
        end
    end

endmodule

// File: tests/dcache_tb.sv
`include "dcache_cfg.svh"

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    localparam int MEM_LATENCY    = 3;
    // about 310 accesses with worst-case misses near 10 cycles plus wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk = 1'b0;
    logic       rst;
    logic       core_sel;
    word_addr_t core_addr;
    word_t      core_wdata;
    byte_mask_t core_wmask;
    word_t      core_rdata;
    logic       core_stall;
    word_addr_t mem_addr;
    logic       mem_valid;
    word_t      mem_wdata;
    byte_mask_t mem_wstrb;
    word_t      mem_rdata;
    logic       mem_ready;
    int         rd_count;
    int         wb_count;
    word_addr_t last_wb_addr;
    word_t      last_wb_data;

    // value every address should read
    word_t  shadow [2**`DC_WORD_ADDR_W];
    int     cycle_cnt = 0;
    int     error_cnt = 0;
    int     check_cnt = 0;
    int     test_cnt  = 0;
    integer seed      = 65;

    always #4 clk = ~clk;

    dcache_top i_dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .core_sel_i   (core_sel),
        .core_addr_i  (core_addr),
        .core_wdata_i (core_wdata),
        .core_wmask_i (core_wmask),
        .core_rdata_o (core_rdata),
        .core_stall_o (core_stall),
        .mem_addr_o   (mem_addr),
        .mem_valid_o  (mem_valid),
        .mem_wdata_o  (mem_wdata),
        .mem_wstrb_o  (mem_wstrb),
        .mem_rdata_i  (mem_rdata),
        .mem_ready_i  (mem_ready)
    );

    main_mem_model #(
        .LATENCY (MEM_LATENCY)
    ) i_mem (
        .clk_i          (clk),
        .rst_i          (rst),
        .valid_i        (mem_valid),
        .addr_i         (mem_addr),
        .wdata_i        (mem_wdata),
        .wstrb_i        (mem_wstrb),
        .rdata_o        (mem_rdata),
        .ready_o        (mem_ready),
        .rd_count_o     (rd_count),
        .wb_count_o     (wb_count),
        .last_wb_addr_o (last_wb_addr),
        .last_wb_data_o (last_wb_data)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic word_t preload_word(input word_addr_t a);
        return {~a[14:0], a};
    endfunction

    function automatic word_addr_t make_addr(input tag_t tag, input set_idx_t idx);
        return {tag, idx};
    endfunction

    // enabled bytes of new_w replace those of old_w
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input byte_mask_t mask);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input word_addr_t got,
                              input word_addr_t exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            error_cnt++;
            $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (error_cnt == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_cnt - errs_before);
        end
    endtask

    // one core request where lat counts cycles until stall falls
    task automatic access(input word_addr_t addr, input word_t wdata, input byte_mask_t mask,
                          output word_t rdata, output int lat);
        @(posedge clk);
        core_sel   <= 1'b1;
        core_addr  <= addr;
        core_wdata <= wdata;
        core_wmask <= mask;
        lat = 0;
        @(negedge clk);
        while (core_stall) begin
            @(negedge clk);
            lat++;
        end
        rdata = core_rdata;
        @(posedge clk);
        core_sel   <= 1'b0;
        core_wmask <= 4'h0;
        if (mask != 4'h0) begin
            shadow[addr] = merge_bytes(shadow[addr], wdata, mask);
        end
    endtask

    task automatic cold_read_miss();
        int         errs_before;
        int         rd_before;
        int         wb_before;
        int         lat;
        word_t      rdata;
        word_addr_t addr;
        errs_before = error_cnt;
        addr = make_addr(9'h005, 8'h10);
        rd_before = rd_count;
        wb_before = wb_count;
        access(addr, '0, 4'h0, rdata, lat);
        check_word("core_rdata_o", rdata, preload_word(addr));
        check_count("mem reads", rd_count - rd_before, 1);
        check_count("mem write-backs", wb_count - wb_before, 0);
        report_test("cold_read_miss", errs_before);
    endtask

    task automatic read_hit();
        int         errs_before;
        int         rd_before;
        int         wb_before;
        int         lat;
        word_t      rdata;
        word_addr_t addr;
        errs_before = error_cnt;
        addr = make_addr(9'h005, 8'h10);
        rd_before = rd_count;
        wb_before = wb_count;
        access(addr, '0, 4'h0, rdata, lat);
        check_word("core_rdata_o", rdata, preload_word(addr));
        check_count("read hit latency", lat, 2);
        check_count("mem reads", rd_count - rd_before, 0);
        check_count("mem write-backs", wb_count - wb_before, 0);
        report_test("read_hit", errs_before);
    endtask

    task automatic write_paths();
        int         errs_before;
        int         rd_before;
        int         wb_before;
        int         lat;
        word_t      rdata;
        word_t      pre;
        word_addr_t addr;
        errs_before = error_cnt;
        // full word allocates with no fetch
        addr = make_addr(9'h007, 8'h11);
        rd_before = rd_count;
        wb_before = wb_count;
        access(addr, 32'hC0DE_1234, 4'hF, rdata, lat);
        check_count("full write latency", lat, 3);
        access(addr, '0, 4'h0, rdata, lat);
        check_word("core_rdata_o", rdata, 32'hC0DE_1234);
        check_count("mem reads", rd_count - rd_before, 0);
        check_count("mem write-backs", wb_count - wb_before, 0);
        // bytes 0 and 2 over the fetched word
        addr = make_addr(9'h00A, 8'h12);
        pre  = preload_word(addr);
        access(addr, 32'h1122_3344, 4'b0101, rdata, lat);
        access(addr, '0, 4'h0, rdata, lat);
        check_word("core_rdata_o", rdata, {pre[31:24], 8'h22, pre[15:8], 8'h44});
        report_test("write_paths", errs_before);
    endtask

    task automatic eviction();
        int         errs_before;
        int         wb_before;
        int         lat;
        word_t      rdata;
        word_addr_t addr_a;
        word_addr_t addr_b;
        word_addr_t addr_c;
        errs_before = error_cnt;
        addr_a = make_addr(9'h011, 8'h20);
        addr_b = make_addr(9'h022, 8'h20);
        addr_c = make_addr(9'h033, 8'h20);
        access(addr_a, 32'hA11C_E001, 4'hF, rdata, lat);
        access(addr_b, 32'hB0B0_2002, 4'hF, rdata, lat);
        // a read hit on a leaves b least recently touched
        access(addr_a, '0, 4'h0, rdata, lat);
        check_word("core_rdata_o", rdata, 32'hA11C_E001);
        wb_before = wb_count;
        // third tag evicts b
        access(addr_c, '0, 4'h0, rdata, lat);
        check_word("core_rdata_o", rdata, preload_word(addr_c));
        check_count("mem write-backs", wb_count - wb_before, 1);
        check_addr("mem_addr_o", last_wb_addr, addr_b);
        check_word("mem_wdata_o", last_wb_data, 32'hB0B0_2002);
        access(addr_b, '0, 4'h0, rdata, lat);
        check_word("core_rdata_o", rdata, 32'hB0B0_2002);
        report_test("eviction", errs_before);
    endtask

    task automatic random_mix();
        int          errs_before;
        int          lat;
        logic [31:0] rnd;
        word_addr_t  addr;
        word_t       wdata;
        byte_mask_t  mask;
        word_t       rdata;
        word_t       exp;
        errs_before = error_cnt;
        // four tags on four sets so both ways keep getting evicted
        for (int n = 0; n < 300; n++) begin
            rnd   = $random(seed);
            addr  = make_addr(9'h1C0 | {7'b0, rnd[9:8]}, 8'h60 | {6'b0, rnd[11:10]});
            wdata = $random(seed);
            mask  = rnd[4] ? 4'h0 : rnd[3:0];
            exp   = shadow[addr];
            access(addr, wdata, mask, rdata, lat);
            if (mask == 4'h0) begin
                check_word("core_rdata_o", rdata, exp);
            end
        end
        report_test("random_mix", errs_before);
    endtask

    initial begin
        rst        = 1'b1;
        core_sel   = 1'b0;
        core_addr  = '0;
        core_wdata = '0;
        core_wmask = 4'h0;
        for (int a = 0; a < 2**`DC_WORD_ADDR_W; a++) begin
            shadow[word_addr_t'(a)] = preload_word(word_addr_t'(a));
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        cold_read_miss();
        read_hit();
        write_paths();
        eviction();
        random_mix();
        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tests/main_mem_model.sv
`include "dcache_cfg.svh"

module main_mem_model #(
    parameter int LATENCY = 3
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // request from the cache
    input  logic                   valid_i,
    input  dcache_pkg::word_addr_t addr_i,
    input  dcache_pkg::word_t      wdata_i,
    input  dcache_pkg::byte_mask_t wstrb_i,
    output dcache_pkg::word_t      rdata_o,
    output logic                   ready_o,
    // traffic log
    output int                     rd_count_o,
    output int                     wb_count_o,
    output dcache_pkg::word_addr_t last_wb_addr_o,
    output dcache_pkg::word_t      last_wb_data_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import dcache_pkg::*;

    word_t mem [2**`DC_WORD_ADDR_W];
    int    wait_cnt;

    // preload, every address bit shows up in the word
    function automatic word_t fill_pattern(input word_addr_t a);
        return {~a[14:0], a};
    endfunction

    initial begin
        for (int a = 0; a < 2**`DC_WORD_ADDR_W; a++) begin
            mem[word_addr_t'(a)] = fill_pattern(word_addr_t'(a));
        end
    end

    // ready pulses LATENCY cycles after valid is first seen
    always @(posedge clk_i) begin
        if (rst_i) begin
            ready_o        <= 1'b0;
            rdata_o        <= '0;
            wait_cnt       <= 0;
            rd_count_o     <= 0;
            wb_count_o     <= 0;
            last_wb_addr_o <= '0;
            last_wb_data_o <= '0;
        end else if (ready_o) begin
            ready_o  <= 1'b0;
            wait_cnt <= 0;
        end else if (valid_i) begin
            if (wait_cnt == LATENCY - 1) begin
                ready_o <= 1'b1;
                if (wstrb_i == 4'hF) begin
                    mem[addr_i] = wdata_i;
                    wb_count_o     <= wb_count_o + 1;
                    last_wb_addr_o <= addr_i;
                    last_wb_data_o <= wdata_i;
                end else begin
                    rdata_o    <= mem[addr_i];
                    rd_count_o <= rd_count_o + 1;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule

// File: vlog.f
+incdir+source
source/dcache_pkg.sv
source/dcache_way_ram.sv
source/dcache_line_state.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tests/main_mem_model.sv
tests/dcache_tb.sv
